// ==== design/fifo_pkg.sv ====
package fifo_pkg;

    // axi-lite register port widths
    localparam int CSR_ADDR_W = 5;
    localparam int CSR_DATA_W = 32;

    // register byte addresses
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CTRL   = 5'h00, // bit 0 flush, self clearing
        CSR_AF_TH  = 5'h04,
        CSR_AE_TH  = 5'h08,
        CSR_STATUS = 5'h0C, // read only
        CSR_ERR    = 5'h10  // write 1 to clear
    } csr_addr_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // bit positions in CSR_STATUS
    localparam int ST_EMPTY   = 0;
    localparam int ST_FULL    = 1;
    localparam int ST_AEMPTY  = 2;
    localparam int ST_AFULL   = 3;
    localparam int ST_CNT_LSB = 8; // data count from here up

endpackage

// ==== design/fifo_mem_if.sv ====
interface fifo_mem_if #(
    parameter int DEPTH      = 16,
    parameter int DATA_WIDTH = 32
) (
    input logic clk,
    input logic rst_n
);
    logic                     wen;
    logic [$clog2(DEPTH)-1:0] waddr;
    logic [DATA_WIDTH-1:0]    wdata;
    logic                     ren;
    logic [$clog2(DEPTH)-1:0] raddr;
    logic [DATA_WIDTH-1:0]    rdata;

    modport ctrl (output wen, waddr, wdata, ren, raddr, input rdata);
    modport mem (input wen, waddr, wdata, ren, raddr, output rdata);

    // the controller never reads the slot it is writing in the same cycle
    a_no_rw_collision : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wen && ren) |-> (waddr != raddr)
    );

endinterface

// ==== design/fifo_ctrl.sv ====
module fifo_ctrl #(
    parameter int DEPTH      = 16,
    parameter int DATA_WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // write side
    input  logic                     wr_en,
    input  logic [DATA_WIDTH-1:0]    wr_data,
    // read side
    input  logic                     rd_en,
    output logic [DATA_WIDTH-1:0]    rd_data,
    output logic                     rd_valid,
    // from the register block
    input  logic                     flush,
    input  logic [$clog2(DEPTH):0]   af_th,
    input  logic [$clog2(DEPTH):0]   ae_th,
    // flags and count
    output logic                     empty,
    output logic                     full,
    output logic                     almost_empty,
    output logic                     almost_full,
    output logic [$clog2(DEPTH):0]   data_cnt,
    output logic                     ovf_pulse,
    output logic                     udf_pulse,
    fifo_mem_if.ctrl                 mem_if
);
    localparam int AW = $clog2(DEPTH);

    logic [AW-1:0] wptr;
    logic [AW-1:0] rptr;
    logic [AW:0]   cnt;
    logic [AW:0]   cnt_nxt;
    logic          wr_ok;
    logic          rd_ok;

    assign wr_ok = wr_en & ~full;  // accepted write
    assign rd_ok = rd_en & ~empty; // accepted read

    // rejected requests become sticky bits in the register block
    assign ovf_pulse = wr_en & full;
    assign udf_pulse = rd_en & empty;

    always_comb
    begin
        case ({wr_ok, rd_ok})
            2'b10:   cnt_nxt = cnt + 1'b1;
            2'b01:   cnt_nxt = cnt - 1'b1;
            default: cnt_nxt = cnt; // both or neither
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wptr         <= '0;
            rptr         <= '0;
            cnt          <= '0;
            empty        <= 1'b1;
            full         <= 1'b0;
            almost_empty <= 1'b1;
            almost_full  <= 1'b0;
            rd_valid     <= 1'b0;
        end
        else if (flush)
        begin
            // back to the reset state and wins over any transfer
            wptr         <= '0;
            rptr         <= '0;
            cnt          <= '0;
            empty        <= 1'b1;
            full         <= 1'b0;
            almost_empty <= 1'b1;
            almost_full  <= 1'b0;
            rd_valid     <= 1'b0;
        end
        else
        begin
            if (wr_ok)
                wptr <= wptr + 1'b1;
            if (rd_ok)
                rptr <= rptr + 1'b1;
            cnt <= cnt_nxt;

            // empty/full only move when exactly one side transfers
            if (wr_ok ^ rd_ok)
            begin
                if (wr_ok)
                begin
                    empty <= 1'b0;
                    full  <= (cnt == DEPTH - 1);
                end
                else
                begin
                    empty <= (cnt == 1);
                    full  <= 1'b0;
                end
            end

            // thresholds may change at any time, so refresh every cycle
            almost_empty <= (cnt_nxt <= ae_th);
            almost_full  <= (cnt_nxt >= af_th);

            rd_valid <= rd_ok; // lines up with the ram read latency
        end
    end

    assign data_cnt = cnt;

    // ram ports
    assign mem_if.wen   = wr_ok;
    assign mem_if.waddr = wptr;
    assign mem_if.wdata = wr_data;
    assign mem_if.ren   = rd_ok;
    assign mem_if.raddr = rptr;
    assign rd_data      = mem_if.rdata;

    a_cnt_max : assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt <= DEPTH
    );

    a_no_write_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_if.wen |-> (cnt < DEPTH)
    );

    a_flags_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(empty && full)
    );

endmodule

// ==== design/sdp_ram.sv ====
module sdp_ram #(
    parameter int DEPTH      = 16,
    parameter int DATA_WIDTH = 32
) (
    input logic     clk,
    fifo_mem_if.mem mem_if
);
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk)
    begin
        if (mem_if.wen)
        begin
            mem[mem_if.waddr] <= mem_if.wdata;
        end
    end

    // registered read, data one cycle after ren
    always_ff @(posedge clk)
    begin
        if (mem_if.ren)
        begin
            mem_if.rdata <= mem[mem_if.raddr];
        end
    end

endmodule

// ==== design/fifo_csr.sv ====
module fifo_csr #(
    parameter int DEPTH       = 16,
    parameter int AF_TH_RESET = 12,
    parameter int AE_TH_RESET = 3
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // axi4-lite slave
    input  logic [fifo_pkg::CSR_ADDR_W-1:0] s_axil_awaddr,
    input  logic                            s_axil_awvalid,
    output logic                            s_axil_awready,
    input  logic [fifo_pkg::CSR_DATA_W-1:0] s_axil_wdata,
    input  logic                            s_axil_wvalid,
    output logic                            s_axil_wready,
    output logic [1:0]                      s_axil_bresp,
    output logic                            s_axil_bvalid,
    input  logic                            s_axil_bready,
    input  logic [fifo_pkg::CSR_ADDR_W-1:0] s_axil_araddr,
    input  logic                            s_axil_arvalid,
    output logic                            s_axil_arready,
    output logic [fifo_pkg::CSR_DATA_W-1:0] s_axil_rdata,
    output logic [1:0]                      s_axil_rresp,
    output logic                            s_axil_rvalid,
    input  logic                            s_axil_rready,
    // controller status in
    input  logic                            empty,
    input  logic                            full,
    input  logic                            almost_empty,
    input  logic                            almost_full,
    input  logic [$clog2(DEPTH):0]          data_cnt,
    input  logic                            ovf_pulse,
    input  logic                            udf_pulse,
    // controls out
    output logic [$clog2(DEPTH):0]          af_th,
    output logic [$clog2(DEPTH):0]          ae_th,
    output logic                            flush
);
    import fifo_pkg::*;

    localparam int CW = $clog2(DEPTH) + 1;

    typedef enum logic [1:0] {CSR_IDLE, CSR_WRESP, CSR_RRESP} csr_state_e;

    csr_state_e            state;
    csr_addr_e             waddr;
    csr_addr_e             raddr;
    axi_resp_e             bresp_q;
    axi_resp_e             bresp_nxt;
    axi_resp_e             rresp_q;
    axi_resp_e             rresp_nxt;
    logic [CSR_DATA_W-1:0] rdata_q;
    logic [CSR_DATA_W-1:0] rdata_nxt;
    logic                  err_ovf;
    logic                  err_udf;
    logic                  wr_take;
    logic                  rd_take;
    logic                  th_ok;

    assign waddr = csr_addr_e'(s_axil_awaddr);
    assign raddr = csr_addr_e'(s_axil_araddr);
    assign th_ok = (s_axil_wdata >= 1) && (s_axil_wdata <= DEPTH - 1);

    // write needs address and data together, and beats a read
    assign wr_take        = (state == CSR_IDLE) && s_axil_awvalid && s_axil_wvalid;
    assign s_axil_awready = wr_take;
    assign s_axil_wready  = wr_take;
    assign s_axil_arready = (state == CSR_IDLE) && !(s_axil_awvalid && s_axil_wvalid);
    assign rd_take        = s_axil_arvalid && s_axil_arready;

    always_comb
    begin
        case (waddr)
            CSR_AF_TH, CSR_AE_TH: bresp_nxt = th_ok ? RESP_OKAY : RESP_SLVERR;
            CSR_CTRL, CSR_STATUS, CSR_ERR: bresp_nxt = RESP_OKAY; // status writes ignored
            default: bresp_nxt = RESP_SLVERR;
        endcase
    end

    always_comb
    begin
        rdata_nxt = '0;
        rresp_nxt = RESP_OKAY;
        case (raddr)
            CSR_CTRL:  rdata_nxt = '0; // flush is write only
            CSR_AF_TH: rdata_nxt[CW-1:0] = af_th;
            CSR_AE_TH: rdata_nxt[CW-1:0] = ae_th;
            CSR_STATUS:
            begin
                rdata_nxt[ST_EMPTY]            = empty;
                rdata_nxt[ST_FULL]             = full;
                rdata_nxt[ST_AEMPTY]           = almost_empty;
                rdata_nxt[ST_AFULL]            = almost_full;
                rdata_nxt[ST_CNT_LSB +: CW]    = data_cnt;
            end
            CSR_ERR:   rdata_nxt[1:0] = {err_udf, err_ovf};
            default:   rresp_nxt = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= CSR_IDLE;
            bresp_q <= RESP_OKAY;
            rresp_q <= RESP_OKAY;
        end
        else
        begin
            case (state)
                CSR_IDLE:
                begin
                    if (wr_take)
                    begin
                        state   <= CSR_WRESP;
                        bresp_q <= bresp_nxt;
                    end
                    else if (rd_take)
                    begin
                        state   <= CSR_RRESP;
                        rresp_q <= rresp_nxt;
                    end
                end
                CSR_WRESP: if (s_axil_bready) state <= CSR_IDLE;
                CSR_RRESP: if (s_axil_rready) state <= CSR_IDLE;
                default:   state <= CSR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_take)
            rdata_q <= rdata_nxt;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            af_th   <= CW'(AF_TH_RESET);
            ae_th   <= CW'(AE_TH_RESET);
            flush   <= 1'b0;
            err_ovf <= 1'b0;
            err_udf <= 1'b0;
        end
        else
        begin
            flush <= wr_take && (waddr == CSR_CTRL) && s_axil_wdata[0]; // one shot
            if (wr_take && (waddr == CSR_AF_TH) && th_ok)
                af_th <= s_axil_wdata[CW-1:0];
            if (wr_take && (waddr == CSR_AE_TH) && th_ok)
                ae_th <= s_axil_wdata[CW-1:0];
            // a new event outranks the clear
            err_ovf <= ovf_pulse | (err_ovf & ~(wr_take && (waddr == CSR_ERR) && s_axil_wdata[0]));
            err_udf <= udf_pulse | (err_udf & ~(wr_take && (waddr == CSR_ERR) && s_axil_wdata[1]));
        end
    end

    assign s_axil_bvalid = (state == CSR_WRESP);
    assign s_axil_bresp  = bresp_q;
    assign s_axil_rvalid = (state == CSR_RRESP);
    assign s_axil_rresp  = rresp_q;
    assign s_axil_rdata  = rdata_q;

    a_bvalid_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (s_axil_bvalid && !s_axil_bready) |=> s_axil_bvalid
    );

    a_rvalid_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (s_axil_rvalid && !s_axil_rready) |=> s_axil_rvalid
    );

    a_flush_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !flush
    );

endmodule

// ==== design/fifo_top.sv ====
module fifo_top #(
    parameter int DEPTH       = 16,
    parameter int DATA_WIDTH  = 32,
    parameter int AF_TH_RESET = 12,
    parameter int AE_TH_RESET = 3
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // write side
    input  logic                            wr_en,
    input  logic [DATA_WIDTH-1:0]           wr_data,
    output logic                            full,
    output logic                            almost_full,
    // read side
    input  logic                            rd_en,
    output logic [DATA_WIDTH-1:0]           rd_data,
    output logic                            rd_valid,
    output logic                            empty,
    output logic                            almost_empty,
    // register port
    input  logic [fifo_pkg::CSR_ADDR_W-1:0] s_axil_awaddr,
    input  logic                            s_axil_awvalid,
    output logic                            s_axil_awready,
    input  logic [fifo_pkg::CSR_DATA_W-1:0] s_axil_wdata,
    input  logic                            s_axil_wvalid,
    output logic                            s_axil_wready,
    output logic [1:0]                      s_axil_bresp,
    output logic                            s_axil_bvalid,
    input  logic                            s_axil_bready,
    input  logic [fifo_pkg::CSR_ADDR_W-1:0] s_axil_araddr,
    input  logic                            s_axil_arvalid,
    output logic                            s_axil_arready,
    output logic [fifo_pkg::CSR_DATA_W-1:0] s_axil_rdata,
    output logic [1:0]                      s_axil_rresp,
    output logic                            s_axil_rvalid,
    input  logic                            s_axil_rready
);
    logic [$clog2(DEPTH):0] af_th;
    logic [$clog2(DEPTH):0] ae_th;
    logic [$clog2(DEPTH):0] data_cnt;
    logic                   flush;
    logic                   ovf_pulse;
    logic                   udf_pulse;

    fifo_mem_if #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) mem_if (.clk(clk), .rst_n(rst_n));

    fifo_csr #(
        .DEPTH(DEPTH), .AF_TH_RESET(AF_TH_RESET), .AE_TH_RESET(AE_TH_RESET)
    ) u_csr (
        .clk(clk), .rst_n(rst_n),
        .s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awready(s_axil_awready),
        .s_axil_wdata(s_axil_wdata), .s_axil_wvalid(s_axil_wvalid),
        .s_axil_wready(s_axil_wready),
        .s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
        .s_axil_bready(s_axil_bready),
        .s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
        .s_axil_arready(s_axil_arready),
        .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
        .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
        .empty(empty), .full(full), .almost_empty(almost_empty), .almost_full(almost_full),
        .data_cnt(data_cnt), .ovf_pulse(ovf_pulse), .udf_pulse(udf_pulse),
        .af_th(af_th), .ae_th(ae_th), .flush(flush)
    );

    fifo_ctrl #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_data(wr_data),
        .rd_en(rd_en), .rd_data(rd_data), .rd_valid(rd_valid),
        .flush(flush), .af_th(af_th), .ae_th(ae_th),
        .empty(empty), .full(full), .almost_empty(almost_empty), .almost_full(almost_full),
        .data_cnt(data_cnt), .ovf_pulse(ovf_pulse), .udf_pulse(udf_pulse),
        .mem_if(mem_if.ctrl)
    );

    sdp_ram #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_ram (
        .clk(clk),
        .mem_if(mem_if.mem)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== bench/tb_fifo_top.sv ====
module tb_fifo_top;
    timeunit 1ns;
    timeprecision 1ps;

    import fifo_pkg::*;

    localparam int DEPTH       = 16;
    localparam int DATA_WIDTH  = 32;
    localparam int AF_TH_RESET = 12;
    localparam int AE_TH_RESET = 3;
    localparam int AXI_TIMEOUT = 16; // cycles per handshake
    localparam int STIM_CYCLES = 2000 + 8 * (2 * DEPTH + 4) + 6 * DEPTH + 20;
    localparam int AXI_TRANS   = 60;
    localparam int WATCHDOG_NS = 20 * (STIM_CYCLES + 6 * AXI_TRANS) + 5000;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  full;
    logic                  almost_full;
    logic                  rd_en;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_valid;
    logic                  empty;
    logic                  almost_empty;
    logic [CSR_ADDR_W-1:0] s_axil_awaddr;
    logic                  s_axil_awvalid;
    logic                  s_axil_awready;
    logic [CSR_DATA_W-1:0] s_axil_wdata;
    logic                  s_axil_wvalid;
    logic                  s_axil_wready;
    logic [1:0]            s_axil_bresp;
    logic                  s_axil_bvalid;
    logic                  s_axil_bready;
    logic [CSR_ADDR_W-1:0] s_axil_araddr;
    logic                  s_axil_arvalid;
    logic                  s_axil_arready;
    logic [CSR_DATA_W-1:0] s_axil_rdata;
    logic [1:0]            s_axil_rresp;
    logic                  s_axil_rvalid;
    logic                  s_axil_rready;

    // reference model
    logic [DATA_WIDTH-1:0] model_q[$];
    int                    af_model;
    int                    ae_model;
    bit                    ovf_model;
    bit                    udf_model;
    bit                    exp_valid; // a read beat is due after the next edge
    logic [DATA_WIDTH-1:0] exp_data;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    fifo_top dut (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_data(wr_data), .full(full), .almost_full(almost_full),
        .rd_en(rd_en), .rd_data(rd_data), .rd_valid(rd_valid),
        .empty(empty), .almost_empty(almost_empty),
        .s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awready(s_axil_awready),
        .s_axil_wdata(s_axil_wdata), .s_axil_wvalid(s_axil_wvalid),
        .s_axil_wready(s_axil_wready),
        .s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
        .s_axil_bready(s_axil_bready),
        .s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
        .s_axil_arready(s_axil_arready),
        .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
        .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready)
    );

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0d ns %s expected %0h got %0h", $time, name, exp, got);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string what);
        $display("%0d ns %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] status_word();
        logic [31:0] w;
        int          cnt;
        cnt                 = model_q.size();
        w                   = '0;
        w[ST_EMPTY]         = (cnt == 0);
        w[ST_FULL]          = (cnt == DEPTH);
        w[ST_AEMPTY]        = (cnt <= ae_model);
        w[ST_AFULL]         = (cnt >= af_model);
        w[ST_CNT_LSB +: 8]  = cnt[7:0];
        return w;
    endfunction

    task automatic check_flags();
        logic [31:0] w;
        w = status_word();
        check_val("empty", w[ST_EMPTY], empty);
        check_val("full", w[ST_FULL], full);
        check_val("almost_empty", w[ST_AEMPTY], almost_empty);
        check_val("almost_full", w[ST_AFULL], almost_full);
    endtask

    // one fifo cycle checks what the last edge produced and then drives the next request
    task automatic step(input bit wr, input bit rd);
        logic [DATA_WIDTH-1:0] data;
        int                    cnt_before;
        @(negedge clk);
        check_val("rd_valid", exp_valid, rd_valid);
        if (exp_valid)
            check_val("rd_data", exp_data, rd_data);
        check_flags();
        data       = $urandom;
        cnt_before = model_q.size();
        exp_valid  = 1'b0;
        if (rd && cnt_before > 0)
        begin
            exp_data  = model_q.pop_front();
            exp_valid = 1'b1;
        end
        if (wr && cnt_before < DEPTH)
            model_q.push_back(data);
        if (wr && cnt_before == DEPTH)
            ovf_model = 1'b1;
        if (rd && cnt_before == 0)
            udf_model = 1'b1;
        wr_en   = wr;
        rd_en   = rd;
        wr_data = data;
    endtask

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        @(negedge clk);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        n = 0;
        #1;
        while (!s_axil_awready)
        begin
            @(negedge clk);
            #1;
            n++;
            if (n > AXI_TIMEOUT)
                fail_now("register write address was never accepted");
        end
        check_val("s_axil_wready", 1'b1, s_axil_wready); // pulses with awready
        @(negedge clk); // accepted at the edge just passed
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        n = 0;
        while (!s_axil_bvalid)
        begin
            @(negedge clk);
            n++;
            if (n > AXI_TIMEOUT)
                fail_now("register write got no response");
        end
        resp = s_axil_bresp;
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(negedge clk);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        n = 0;
        #1;
        while (!s_axil_arready)
        begin
            @(negedge clk);
            #1;
            n++;
            if (n > AXI_TIMEOUT)
                fail_now("register read address was never accepted");
        end
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        n = 0;
        while (!s_axil_rvalid)
        begin
            @(negedge clk);
            n++;
            if (n > AXI_TIMEOUT)
                fail_now("register read got no response");
        end
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic reg_write_expect(input logic [4:0] addr, input logic [31:0] data,
                                    input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_val("s_axil_bresp", exp_resp, resp);
        if (addr == CSR_ERR)
        begin
            ovf_model = ovf_model & ~data[0];
            udf_model = udf_model & ~data[1];
        end
    endtask

    task automatic reg_read_expect(input logic [4:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_val("s_axil_rresp", RESP_OKAY, resp);
        check_val("s_axil_rdata", exp, data);
    endtask

    task automatic fill_to(input int level);
        while (model_q.size() < level)
            step(1'b1, 1'b0);
        while (model_q.size() > level)
            step(1'b0, 1'b1);
        step(1'b0, 1'b0); // no beat left in flight
    endtask

    task automatic run_random_traffic(input int cycles);
        int wr_pct;
        wr_pct = 50;
        for (int i = 0; i < cycles; i++)
        begin
            if (i % 100 == 0)
                wr_pct = $urandom_range(80, 20); // drift between filling and draining
            step(($urandom % 100) < wr_pct, ($urandom % 100) >= wr_pct);
        end
        step(1'b0, 1'b0);
    endtask

    task automatic check_thresholds();
        int th;
        for (int i = 0; i < 8; i++)
        begin
            fill_to($urandom_range(DEPTH, 0));
            th = $urandom_range(DEPTH - 1, 1);
            reg_write_expect(CSR_AF_TH, th, RESP_OKAY);
            af_model = th;
            reg_read_expect(CSR_AF_TH, th);
            th = $urandom_range(DEPTH - 1, 1);
            reg_write_expect(CSR_AE_TH, th, RESP_OKAY);
            ae_model = th;
            reg_read_expect(CSR_AE_TH, th);
            repeat (3) step(1'b0, 1'b0);
        end
        // out of range values are refused
        reg_write_expect(CSR_AF_TH, 0, RESP_SLVERR);
        reg_write_expect(CSR_AF_TH, DEPTH, RESP_SLVERR);
        reg_read_expect(CSR_AF_TH, af_model);
        reg_write_expect(CSR_AE_TH, 0, RESP_SLVERR);
        reg_write_expect(CSR_AE_TH, DEPTH, RESP_SLVERR);
        reg_read_expect(CSR_AE_TH, ae_model);
    endtask

    task automatic check_overflow_underflow();
        step(1'b0, 1'b0);
        reg_write_expect(CSR_ERR, 32'h3, RESP_OKAY);
        reg_read_expect(CSR_ERR, 32'h0);
        fill_to(DEPTH);
        step(1'b1, 1'b0); // dropped write
        step(1'b0, 1'b0);
        reg_read_expect(CSR_ERR, {30'b0, udf_model, ovf_model});
        reg_read_expect(CSR_STATUS, status_word());
        reg_write_expect(CSR_ERR, 32'h1, RESP_OKAY);
        reg_read_expect(CSR_ERR, 32'h0);
        fill_to(0); // contents must come out untouched
        step(1'b0, 1'b1); // read of an empty fifo
        step(1'b0, 1'b0);
        reg_read_expect(CSR_ERR, {30'b0, udf_model, ovf_model});
        reg_write_expect(CSR_ERR, 32'h2, RESP_OKAY);
        reg_read_expect(CSR_ERR, 32'h0);
    endtask

    task automatic check_flush();
        fill_to($urandom_range(DEPTH, 1));
        reg_write_expect(CSR_CTRL, 32'h1, RESP_OKAY);
        model_q.delete();
        reg_read_expect(CSR_STATUS, status_word());
        repeat (6) step(1'b1, 1'b0);
        fill_to(0);
    endtask

    initial
    begin
        void'($urandom(32'hfd08_5787));
        wr_en          = 1'b0;
        wr_data        = '0;
        rd_en          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        af_model       = AF_TH_RESET;
        ae_model       = AE_TH_RESET;
        ovf_model      = 1'b0;
        udf_model      = 1'b0;
        exp_valid      = 1'b0;
        exp_data       = '0;
        wait (rst_n === 1'b1);

        reg_read_expect(CSR_STATUS, (32'h1 << ST_EMPTY) | (32'h1 << ST_AEMPTY));
        reg_read_expect(CSR_AF_TH, AF_TH_RESET);
        reg_read_expect(CSR_AE_TH, AE_TH_RESET);
        run_random_traffic(2000);
        check_thresholds();
        check_overflow_underflow();
        check_flush();

        $display("Finished with no errors");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

// ==== project.f ====
design/fifo_pkg.sv
design/fifo_mem_if.sv
design/fifo_ctrl.sv
design/sdp_ram.sv
design/fifo_csr.sv
design/fifo_top.sv
bench/tb_clk_gen.sv
bench/tb_fifo_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fifo testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fifo_top -f project.f -o tb_fifo_top > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_fifo_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

# the log decides, the exit status only backs it up
if grep -q "Finished with errors" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
